// ==== flist.f ====
logic/rider_pkg.sv
logic/ld_cell_avg.sv
logic/steer_en.sv
logic/steer_cmd.sv
logic/rider_sense_top.sv
sim/rider_sense_tb.sv

// ==== sim/rider_sense_tb.sv ====
module rider_sense_tb;

	timeunit 1ns;
	timeprecision 100ps;

	// limits from the rider-sensing rules
	localparam int min_weight = 512;
	localparam int dwell_lim  = 16383;	// fast_sim dwell
	localparam int dband      = 32;
	localparam int tq_max     = 1023;
	localparam int st_idle    = 0;
	localparam int st_wait    = 1;
	localparam int st_steer   = 2;
	localparam int wait_en_hi = 0;	// wait conditions for run_until
	localparam int wait_en_lo = 1;
	localparam int wait_off   = 2;

	logic               clk = 1'b0;
	logic               rst_n;
	logic               smpl_vld;
	logic        [11:0] lft_raw;
	logic        [11:0] rght_raw;
	logic signed [11:0] ld_cell_diff;
	logic               en_steer;
	logic               rider_off;
	logic signed [11:0] steer_torque;

	// cycle model of the chain
	logic        [11:0] m_hist_l [4];	// [0] newest
	logic        [11:0] m_hist_r [4];
	logic        [11:0] m_lft;
	logic        [11:0] m_rght;
	logic signed [11:0] m_diff;
	int m_sum;
	int m_tmr;
	int m_state;
	int m_torque;
	bit m_en_q;				// expected en_steer on the last check
	bit en_q_dut;				// en_steer seen on the last check
	bit off_q;				// rider_off seen on the last check

	int err_cnt     = 0;
	int chk_cnt     = 0;
	int en_rise_cnt = 0;
	int off_cnt     = 0;
	int stepoff_cnt = 0;
	int gap_left    = 1;			// cycles to the next strobe
	bit timed_out   = 1'b0;

	rider_sense_top #(
		.fast_sim (1'b1)
	) u_dut (
		.clk          (clk),
		.rst_n        (rst_n),
		.smpl_vld     (smpl_vld),
		.lft_raw      (lft_raw),
		.rght_raw     (rght_raw),
		.ld_cell_diff (ld_cell_diff),
		.en_steer     (en_steer),
		.rider_off    (rider_off),
		.steer_torque (steer_torque)
	);

	always #2 clk = ~clk;	// 4 ns period

	function automatic logic [11:0] clamp_raw(input int v);
		if (v < 0)
			return 12'd0;
		if (v > 4095)
			return 12'd4095;
		return 12'(v);
	endfunction

	// dead band, then clip, then gate
	function automatic int shape_torque(input int d, input bit en);
		int t;
		t = 0;
		if (d > dband)
			t = d - dband;
		else if (d < -dband)
			t = d + dband;
		if (t > tq_max)
			t = tq_max;
		else if (t < -tq_max)
			t = -tq_max;
		return en ? t : 0;
	endfunction

	// Mealy decision of the rider FSM from the model registers
	task automatic fsm_eval(output int nxt, output bit en, output bit off, output bit clr);
		int abs_d;
		bit present;
		bit absent;
		bit off_ctr;
		bit leaving;
		abs_d   = (m_diff < 0) ? -int'(m_diff) : int'(m_diff);
		present = m_sum > min_weight;
		absent  = m_sum < min_weight;
		off_ctr = abs_d > m_sum / 4;
		leaving = abs_d > (m_sum / 16) * 15;
		nxt = m_state;
		en  = 1'b0;
		off = 1'b0;
		clr = 1'b0;
		case (m_state)
			st_idle: if (present) begin
				nxt = st_wait;
				clr = 1'b1;
			end
			st_wait: begin
				if (absent) begin
					nxt = st_idle;
					off = 1'b1;
				end
				else if (off_ctr)
					clr = 1'b1;	// dwell restarts
				else if (m_tmr >= dwell_lim) begin
					nxt = st_steer;
					en  = 1'b1;
				end
			end
			default: begin
				if (absent) begin
					nxt = st_idle;
					off = 1'b1;
				end
				else if (leaving) begin
					nxt = st_wait;
					clr = 1'b1;
				end
				else
					en = 1'b1;
			end
		endcase
	endtask

	task automatic check_val(input string name, input logic signed [31:0] exp_v,
			input logic signed [31:0] act_v);
		chk_cnt++;
		assert (act_v === exp_v) else begin
			$display("FAIL t=%0t %s expected %0d actual %0d", $time, name, exp_v, act_v);
			err_cnt++;
		end
	endtask

	// model update on the rising edge and compare shortly after it
	always begin : model
		int nxt;
		int dummy_nxt;
		bit en;
		bit off;
		bit clr;
		bit en_exp;
		bit off_exp;
		bit dummy_clr;
		@(posedge clk);
		if (!rst_n) begin
			for (int i = 0; i < 4; i++) begin
				m_hist_l[i] = '0;
				m_hist_r[i] = '0;
			end
			m_lft    = '0;
			m_rght   = '0;
			m_diff   = '0;
			m_sum    = 0;
			m_tmr    = 0;
			m_state  = st_idle;
			m_torque = 0;
			m_en_q   = 1'b0;
			en_q_dut = 1'b0;
			off_q    = 1'b0;
		end
		else begin
			fsm_eval(nxt, en, off, clr);	// all from pre-edge values
			m_torque = shape_torque(m_diff, en);
			if (clr)
				m_tmr = 0;
			else if (m_tmr < dwell_lim)
				m_tmr++;		// saturates at the limit
			if (m_state == st_steer && nxt == st_wait)
				stepoff_cnt++;
			m_state = nxt;
			m_diff  = m_lft - m_rght;	// 12-bit wrap
			m_sum   = m_lft + m_rght;
			if (smpl_vld) begin
				for (int i = 3; i > 0; i--) begin
					m_hist_l[i] = m_hist_l[i-1];
					m_hist_r[i] = m_hist_r[i-1];
				end
				m_hist_l[0] = lft_raw;
				m_hist_r[0] = rght_raw;
				m_lft  = 12'((m_hist_l[0] + m_hist_l[1] + m_hist_l[2] + 14'(m_hist_l[3])) / 4);
				m_rght = 12'((m_hist_r[0] + m_hist_r[1] + m_hist_r[2] + 14'(m_hist_r[3])) / 4);
			end
			#1;
			fsm_eval(dummy_nxt, en_exp, off_exp, dummy_clr);
			check_val("ld_cell_diff", m_diff, ld_cell_diff);
			check_val("steer_torque", m_torque, steer_torque);
			check_val("en_steer", en_exp, en_steer);
			check_val("rider_off", off_exp, rider_off);
			assert (en_q_dut || steer_torque === 12'sd0) else begin
				$display("torque was nonzero after a cycle without steering at t=%0t", $time);
				err_cnt++;
			end
			assert (!(rider_off && off_q)) else begin
				$display("rider_off stayed high for more than one cycle at t=%0t", $time);
				err_cnt++;
			end
			if (en_exp && !m_en_q)
				en_rise_cnt++;
			if (off_exp)
				off_cnt++;
			m_en_q   = en_exp;
			en_q_dut = en_steer;
			off_q    = rider_off;
		end
	end

	// one falling-edge step with the strobe at a random spacing of 1..8
	task automatic drive_cycle(input int base_l, input int base_r, input int jit);
		@(negedge clk);
		if (gap_left <= 1) begin
			smpl_vld = 1'b1;
			lft_raw  = clamp_raw(base_l + int'($urandom_range(jit, 0)) - jit / 2);
			rght_raw = clamp_raw(base_r + int'($urandom_range(jit, 0)) - jit / 2);
			gap_left = $urandom_range(8, 1);
		end
		else begin
			smpl_vld = 1'b0;
			gap_left--;
		end
	endtask

	task automatic run_phase(input int base_l, input int base_r, input int jit, input int ncyc);
		for (int i = 0; i < ncyc; i++)
			drive_cycle(base_l, base_r, jit);
	endtask

	// hold a load pattern until the DUT shows the event or the limit runs out
	task automatic run_until(input int base_l, input int base_r, input int jit,
			input int what, input int limit, input string desc);
		int n;
		bit hit;
		n   = 0;
		hit = 1'b0;
		while (!hit && n < limit) begin
			drive_cycle(base_l, base_r, jit);
			case (what)
				wait_en_hi: hit = en_steer;
				wait_en_lo: hit = !en_steer;
				default:    hit = rider_off;
			endcase
			n++;
		end
		if (!hit) begin
			$display("timeout: %s not seen within %0d cycles", desc, limit);
			err_cnt++;
			timed_out = 1'b1;
		end
	endtask

	task automatic run_scenario();
		run_phase(100, 100, 40, $urandom_range(400, 200));	// empty platform
		run_phase(256, 256, 30, $urandom_range(600, 300));	// light rider near threshold
		run_phase(1400, 300, 60, $urandom_range(4000, 2000));	// off centre, no dwell
		run_until(900, 860, 30, wait_en_hi, dwell_lim + 200, "steering enable on a centred rider");
		if (timed_out)
			return;
		run_phase(900, 860, 30, $urandom_range(500, 200));	// small torque
		run_phase(2000, 900, 60, $urandom_range(300, 100));	// lean left, clips high
		run_phase(850, 2100, 60, $urandom_range(300, 100));	// lean right, clips low
		run_until(1500, 20, 30, wait_en_lo, 200, "steering drop on stepping off");
		if (timed_out)
			return;
		run_phase(1500, 20, 30, $urandom_range(150, 50));
		run_until(40, 20, 20, wait_off, 200, "rider_off from wait_centre");
		if (timed_out)
			return;
		run_phase(40, 20, 20, $urandom_range(200, 100));
		run_until(700, 720, 30, wait_en_hi, dwell_lim + 300, "steering enable on a second rider");
		if (timed_out)
			return;
		run_phase(700, 720, 30, $urandom_range(400, 200));
		run_until(30, 30, 20, wait_off, 200, "rider_off from steer_on");
		if (timed_out)
			return;
		run_phase(30, 30, 20, 100);
	endtask

	initial begin
		void'($urandom(32'hdb84));
		rst_n    = 1'b0;
		smpl_vld = 1'b0;
		lft_raw  = '0;
		rght_raw = '0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		run_scenario();
		repeat (4) @(negedge clk);	// drain the last checks
		assert (en_rise_cnt >= 2) else begin
			$display("steering was not enabled on both riders");
			err_cnt++;
		end
		assert (stepoff_cnt >= 1) else begin
			$display("no step-off from steering was seen");
			err_cnt++;
		end
		assert (off_cnt >= 2) else begin
			$display("fewer rider_off pulses than expected");
			err_cnt++;
		end
		$display("checks: %0d  errors: %0d", chk_cnt, err_cnt);
		if (err_cnt == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

// ==== logic/rider_sense_top.sv ====
module rider_sense_top #(
	parameter bit fast_sim = 0	// short dwell for simulation
) (
	input  logic                             clk,
	input  logic                             rst_n,
	input  logic                             smpl_vld,	// fresh raw pair strobe
	input  logic        [rider_pkg::ld_w-1:0] lft_raw,	// left load cell, raw
	input  logic        [rider_pkg::ld_w-1:0] rght_raw,	// right load cell, raw
	output logic signed [rider_pkg::ld_w-1:0] ld_cell_diff,
	output logic                             en_steer,
	output logic                             rider_off,
	output logic signed [rider_pkg::ld_w-1:0] steer_torque
);

	import rider_pkg::*;

	logic [ld_w-1:0] lft_ld;	// averaged left
	logic [ld_w-1:0] rght_ld;	// averaged right

	// smoothing, updates on the strobe edge
	ld_cell_avg u_avg (
		.clk      (clk),
		.rst_n    (rst_n),
		.smpl_vld (smpl_vld),
		.lft_raw  (lft_raw),
		.rght_raw (rght_raw),
		.lft_ld   (lft_ld),
		.rght_ld  (rght_ld)
	);

	// rider detection, diff one cycle after the averages
	steer_en #(
		.fast_sim (fast_sim)
	) u_steer_en (
		.clk          (clk),
		.rst_n        (rst_n),
		.lft_ld       (lft_ld),
		.rght_ld      (rght_ld),
		.ld_cell_diff (ld_cell_diff),
		.en_steer     (en_steer),
		.rider_off    (rider_off)
	);

	// torque, one more cycle behind
	steer_cmd u_steer_cmd (
		.clk          (clk),
		.rst_n        (rst_n),
		.en_steer     (en_steer),
		.ld_cell_diff (ld_cell_diff),
		.steer_torque (steer_torque)
	);

endmodule

// ==== logic/steer_cmd.sv ====
module steer_cmd (
	input  logic                             clk,
	input  logic                             rst_n,
	input  logic                             en_steer,	// gate from the rider FSM
	input  logic signed [rider_pkg::ld_w-1:0] ld_cell_diff,	// left minus right load
	output logic signed [rider_pkg::ld_w-1:0] steer_torque	// shaped torque command
);

	import rider_pkg::*;

	logic signed [ld_w-1:0] shifted;	// diff moved toward zero by the dead band
	logic signed [ld_w-1:0] torque_nxt;	// clipped and gated value

	// dead band
	// inside +/- steer_dband nothing, outside it pulled in by steer_dband
	// range after the shift is -2016..2015 so 12 bits hold it
	always_comb begin
		shifted = '0;
		if (ld_cell_diff > steer_dband)
			shifted = ld_cell_diff - steer_dband;
		else if (ld_cell_diff < -steer_dband)
			shifted = ld_cell_diff + steer_dband;
	end

	// saturation then gate
	always_comb begin
		if (shifted > steer_max)
			torque_nxt = steer_max;
		else if (shifted < -steer_max)
			torque_nxt = -steer_max;	// symmetric clip
		else
			torque_nxt = shifted;
		if (!en_steer)
			torque_nxt = '0;		// no torque unless steering is live
	end

	// output register, one cycle behind the diff
	always_ff @(posedge clk, negedge rst_n) begin
		if (!rst_n)
			steer_torque <= '0;
		else
			steer_torque <= torque_nxt;
	end

endmodule

// ==== logic/steer_en.sv ====
module steer_en #(
	parameter bit fast_sim = 0	// 1 selects the short dwell
) (
	input  logic                             clk,
	input  logic                             rst_n,
	input  logic        [rider_pkg::ld_w-1:0] lft_ld,		// averaged left cell
	input  logic        [rider_pkg::ld_w-1:0] rght_ld,	// averaged right cell
	output logic signed [rider_pkg::ld_w-1:0] ld_cell_diff,	// left minus right, registered
	output logic                             en_steer,	// steering allowed
	output logic                             rider_off	// one cycle pulse on return to idle
);

	import rider_pkg::*;

	logic [sum_w-1:0] ld_sum;		// registered left plus right
	logic [ld_w-1:0]  abs_diff;		// magnitude of the registered diff
	logic [sum_w-1:0] sum_1_4;		// quarter of the sum
	logic [sum_w-1:0] sum_15_16;		// fifteen sixteenths of the sum

	logic sum_gt_min;			// rider on board
	logic sum_lt_min;			// platform empty
	logic diff_gt_1_4;			// rider not centred
	logic diff_gt_15_16;			// rider stepping off

	logic [tmr_w-1:0] tmr_cnt;		// dwell counter
	logic             tmr_full;		// dwell reached
	logic             clr_tmr;		// restart dwell

	rider_state_t state, nxt_state;

	// diff and sum registers, follow the averages every cycle
	always_ff @(posedge clk, negedge rst_n) begin
		if (!rst_n) begin
			ld_cell_diff <= '0;
			ld_sum       <= '0;
		end
		else begin
			ld_cell_diff <= lft_ld - rght_ld;		// wraps at 12 bits like the cell data
			ld_sum       <= {1'b0, lft_ld} + {1'b0, rght_ld};	// 13 bits, never wraps
		end
	end

	// magnitude, -2048 maps to 2048 which still fits unsigned
	assign abs_diff = ld_cell_diff[ld_w-1] ? $unsigned(-ld_cell_diff) : $unsigned(ld_cell_diff);

	assign sum_1_4   = ld_sum >> 2;
	assign sum_15_16 = (ld_sum >> 4) * 13'd15;	// 15 * (sum / 16), max 7665

	assign sum_gt_min    = ld_sum > min_rider_weight;
	assign sum_lt_min    = ld_sum < min_rider_weight;
	assign diff_gt_1_4   = {1'b0, abs_diff} > sum_1_4;
	assign diff_gt_15_16 = {1'b0, abs_diff} > sum_15_16;

	// dwell limit picked at elaboration
	assign tmr_full = fast_sim ? (tmr_cnt >= tmr_lim_fast) : (tmr_cnt >= tmr_lim_slow);

	// dwell counter, holds once full so a long wait cannot wrap it
	always_ff @(posedge clk, negedge rst_n) begin
		if (!rst_n)
			tmr_cnt <= '0;
		else if (clr_tmr)
			tmr_cnt <= '0;
		else if (!tmr_full)
			tmr_cnt <= tmr_cnt + 1'b1;
	end

	always_ff @(posedge clk, negedge rst_n) begin
		if (!rst_n)
			state <= idle;
		else
			state <= nxt_state;
	end

	// next state and Mealy outputs
	always_comb begin
		nxt_state = state;
		clr_tmr   = 1'b0;
		en_steer  = 1'b0;
		rider_off = 1'b0;
		case (state)
			idle: begin
				if (sum_gt_min) begin
					nxt_state = wait_centre;
					clr_tmr   = 1'b1;	// dwell starts fresh
				end
			end
			wait_centre: begin
				if (sum_lt_min) begin
					nxt_state = idle;
					rider_off = 1'b1;
				end
				else if (diff_gt_1_4)
					clr_tmr = 1'b1;		// off centre restarts the dwell
				else if (tmr_full) begin
					nxt_state = steer_on;
					en_steer  = 1'b1;	// high on the entry cycle too
				end
			end
			steer_on: begin
				if (sum_lt_min) begin
					nxt_state = idle;
					rider_off = 1'b1;
				end
				else if (diff_gt_15_16) begin
					nxt_state = wait_centre;	// back to settling
					clr_tmr   = 1'b1;
				end
				else
					en_steer = 1'b1;
			end
			default: nxt_state = idle;		// unused encoding
		endcase
	end

endmodule

// ==== logic/ld_cell_avg.sv ====
module ld_cell_avg (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      smpl_vld,	// one cycle strobe per fresh pair
	input  logic [rider_pkg::ld_w-1:0] lft_raw,
	input  logic [rider_pkg::ld_w-1:0] rght_raw,
	output logic [rider_pkg::ld_w-1:0] lft_ld,
	output logic [rider_pkg::ld_w-1:0] rght_ld
);

	import rider_pkg::*;

	// both sides run the same datapath, index 0 is left and 1 is right
	logic [ld_w-1:0] raw [2];		// incoming sample per side
	logic [ld_w-1:0] hist [2][4];		// last four samples, [0] newest
	logic [ld_w+1:0] run_sum [2];		// sum of the four history entries

	assign raw[0] = lft_raw;
	assign raw[1] = rght_raw;

	// history shift and running sum
	// the sum adds the new sample and drops the one falling off the end,
	// so it always equals the total of the four history slots
	always_ff @(posedge clk, negedge rst_n) begin
		if (!rst_n) begin
			for (int s = 0; s < 2; s++) begin
				run_sum[s] <= '0;
				for (int i = 0; i < 4; i++) begin
					hist[s][i] <= '0;	// empty history reads as zero load
				end
			end
		end
		else if (smpl_vld) begin
			for (int s = 0; s < 2; s++) begin
				run_sum[s] <= run_sum[s] + {2'b00, raw[s]} - {2'b00, hist[s][3]};
				hist[s][0] <= raw[s];
				for (int i = 1; i < 4; i++) begin
					hist[s][i] <= hist[s][i-1];	// age each slot by one
				end
			end
		end
	end

	// divide by four, truncating
	// outputs come straight off the sum registers so they move on the strobe edge
	// and hold between strobes
	assign lft_ld  = run_sum[0][ld_w+1:2];
	assign rght_ld = run_sum[1][ld_w+1:2];

endmodule

// ==== logic/rider_pkg.sv ====
package rider_pkg;

	// sample and accumulator widths
	localparam int unsigned ld_w  = 12;	// one load cell sample
	localparam int unsigned sum_w = 13;	// left plus right without wrap
	localparam int unsigned tmr_w = 26;	// dwell counter, wide enough for 1.3 s

	// weight threshold on the registered sum
	// above this a rider is on the platform, below it the platform is empty
	localparam logic [sum_w-1:0] min_rider_weight = 13'h200;

	// dwell limits
	localparam logic [tmr_w-1:0] tmr_lim_slow = 26'h3DFD240;	// 1.3 s at 50 MHz
	localparam logic [tmr_w-1:0] tmr_lim_fast = 26'h0003FFF;	// short dwell for simulation

	// steering torque shaping
	localparam logic signed [ld_w-1:0] steer_dband = 12'sd32;	// +/- band around centre
	localparam logic signed [ld_w-1:0] steer_max   = 12'sd1023;	// clip level

	// rider FSM encoding
	typedef enum logic [1:0] {
		idle,		// platform empty
		wait_centre,	// rider on, waiting to settle centred
		steer_on	// steering live
	} rider_state_t;

endpackage
